/* Bender.yml */
package:
  name: cache_store

export_include_dirs:
  - .

sources:
  # design sources in compile order
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - sdp_ram.sv
      - cache_store.sv
      - cache_hit_check.sv
      - cache_top.sv

  # testbench sources
  - target: test
    include_dirs:
      - .
    files:
      - tb_clkgen.sv
      - cache_assert.sv
      - tb_cache_top.sv

/* cache_assert.sv */
`timescale 1ns/1ps

// protocol checks on the cache top level are bound in from outside the design
module cache_assert (
    input logic                   clk,
    input logic                   i_rst_n,
    input logic                   i_rd_en,
    input cache_pkg::cache_addr_t i_rd_addr,
    input logic                   i_rd_valid,
    input cache_pkg::cache_rd_t   i_rd
);

    int fail_count;

    initial begin
        fail_count = 0;
    end

    // every read gives exactly one result one cycle later
    rd_valid_follows_en: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_rd_en |=> i_rd_valid
    ) else begin
        $error("o_rd_valid missing one cycle after i_rd_en");
        fail_count++;
    end

    no_rd_valid_without_en: assert property (
        @(posedge clk) disable iff (!i_rst_n) !i_rd_en |=> !i_rd_valid
    ) else begin
        $error("o_rd_valid high without a read one cycle earlier");
        fail_count++;
    end

    // a hit needs a valid entry whose tag is the one requested a cycle earlier
    hit_needs_valid: assert property (
        @(posedge clk) disable iff (!i_rst_n)
            (i_rd_valid && i_rd.hit) |-> (i_rd.valid && i_rd.tag == $past(i_rd_addr.tag))
    ) else begin
        $error("o_rd.hit set on an entry that is invalid or holds another tag");
        fail_count++;
    end

    rd_valid_low_in_reset: assert property (
        @(posedge clk) !i_rst_n |-> !i_rd_valid
    ) else begin
        $error("o_rd_valid high while reset is asserted");
        fail_count++;
    end

endmodule

bind cache_top cache_assert u_cache_assert (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_rd_en    (i_rd_en),
    .i_rd_addr  (i_rd_addr),
    .i_rd_valid (o_rd_valid),
    .i_rd       (o_rd)
);

/* cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// build-time geometry of the direct-mapped cache
// all derived widths are computed in cache_pkg from these three values

// width of a byte address as seen by the requester
`define CACHE_ADDR_WIDTH 32

// total number of data bytes held by the cache
`define CACHE_SIZE 1024

// bytes per cache line, expected to be a power of two
// the line count is CACHE_SIZE / CACHE_LINE_SIZE and should also be a power of two
`define CACHE_LINE_SIZE 32

`endif

/* cache_hit_check.sv */
`timescale 1ns/1ps

// lookup stage behind the store
// pairs each entry with the tag of the request that read it and decides hit or miss
module cache_hit_check (
    input  logic                    clk,
    input  logic                    i_rst_n,

    // request side, same cycle as the read into the store
    input  logic                    i_rd_en,
    input  cache_pkg::cache_tag_t   i_rd_tag,

    // entry from the store, one cycle after the request
    input  cache_pkg::cache_entry_t i_entry,

    // lookup result, valid for exactly one cycle per request
    output logic                    o_rd_valid,
    output cache_pkg::cache_rd_t    o_rd
);

    import cache_pkg::*;

    logic       rd_valid_r;
    cache_tag_t req_tag_r;
    logic       tag_match;

    // the strobe marks which cycles carry a result
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_valid_r <= 1'b0;
        end else begin
            rd_valid_r <= i_rd_en;
        end
    end

    // the request tag only changes when a new read is issued,
    // the same way the store holds its entry between reads
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            req_tag_r <= i_rd_tag;
        end
    end

    assign tag_match = (i_entry.tag == req_tag_r);

    assign o_rd_valid = rd_valid_r;

    // an invalid entry never hits, whatever its stale tag says
    assign o_rd.hit   = i_entry.valid && tag_match;

    // on a hit these fields are the requested line,
    // on a miss they describe the victim for a later writeback
    assign o_rd.valid = i_entry.valid;
    assign o_rd.dirty = i_entry.dirty;
    assign o_rd.tag   = i_entry.tag;
    assign o_rd.line  = i_entry.line;

endmodule

/* cache_pkg.sv */
`include "cache_config.svh"

package cache_pkg;

    // number of lines in the cache, one line per index
    localparam int INDEX_COUNT = `CACHE_SIZE / `CACHE_LINE_SIZE;

    // a single-line cache still gets a one-bit index so the ports stay legal
    localparam int INDEX_WIDTH = (INDEX_COUNT > 1) ? $clog2(INDEX_COUNT) : 1;

    // byte offset within a line
    localparam int OFFSET_WIDTH = $clog2(`CACHE_LINE_SIZE);

    // whatever the index and offset leave over of the address
    localparam int TAG_WIDTH = `CACHE_ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    localparam int LINE_WIDTH = `CACHE_LINE_SIZE * 8;

    typedef logic [TAG_WIDTH-1:0]  cache_tag_t;
    typedef logic [LINE_WIDTH-1:0] cache_line_t;

    // byte address split into its cache fields, tag in the upper bits
    typedef struct packed {
        cache_tag_t              tag;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
    } cache_addr_t;

    // one write into the store, covering both the state bits and the RAMs
    typedef struct packed {
        logic [INDEX_WIDTH-1:0] index;
        logic                   valid;
        logic                   dirty;
        cache_tag_t             tag;
        cache_line_t            line;
    } cache_wr_t;

    // stored entry as it comes out of the store one cycle after the read
    typedef struct packed {
        logic        valid;
        logic        dirty;
        cache_tag_t  tag;
        cache_line_t line;
    } cache_entry_t;

    // lookup result, on a miss tag and line describe the victim
    typedef struct packed {
        logic        hit;
        logic        valid;
        logic        dirty;
        cache_tag_t  tag;
        cache_line_t line;
    } cache_rd_t;

endpackage

/* cache_store.sv */
`timescale 1ns/1ps

// tag and data store of the direct-mapped cache
// valid and dirty live in flops so they can be cleared on reset,
// tags and lines live in two RAMs that are read side by side
module cache_store (
    input  logic                             clk,
    input  logic                             i_rst_n,

    // write side, one whole entry per write
    input  logic                             i_wr_en,
    input  cache_pkg::cache_wr_t             i_wr,

    // read side, the entry appears one cycle after i_rd_en
    input  logic                             i_rd_en,
    input  logic [cache_pkg::INDEX_WIDTH-1:0] i_rd_index,
    output cache_pkg::cache_entry_t          o_entry
);

    import cache_pkg::*;

    // per-index state bits
    logic [INDEX_COUNT-1:0] valid_r;
    logic [INDEX_COUNT-1:0] dirty_r;

    // state bits selected for the current read, after the bypass
    logic                   wr_rd_same;
    logic                   rd_valid;
    logic                   rd_dirty;

    // state bits registered to line up with the RAM outputs
    logic                   rd_valid_r;
    logic                   rd_dirty_r;

    cache_tag_t             rd_tag;
    cache_line_t            rd_line;

    // any write updates the state of its index, a fill sets valid
    // and a store or a clean fill decides dirty
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_r <= '0;
            dirty_r <= '0;
        end else if (i_wr_en) begin
            valid_r[i_wr.index] <= i_wr.valid;
            dirty_r[i_wr.index] <= i_wr.dirty;
        end
    end

    // a write to the index being read forwards its state bits to the read
    assign wr_rd_same = i_wr_en && (i_wr.index == i_rd_index);
    assign rd_valid   = wr_rd_same ? i_wr.valid : valid_r[i_rd_index];
    assign rd_dirty   = wr_rd_same ? i_wr.dirty : dirty_r[i_rd_index];

    // enabled like the RAM read ports so the whole entry holds between reads
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_valid_r <= 1'b0;
            rd_dirty_r <= 1'b0;
        end else if (i_rd_en) begin
            rd_valid_r <= rd_valid;
            rd_dirty_r <= rd_dirty;
        end
    end

    sdp_ram #(
        .T_DATA (cache_tag_t),
        .DEPTH  (INDEX_COUNT)
    ) tag_ram (
        .clk       (clk),
        .i_rd_en   (i_rd_en),
        .i_rd_addr (i_rd_index),
        .o_rd_data (rd_tag),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr.index),
        .i_wr_data (i_wr.tag)
    );

    sdp_ram #(
        .T_DATA (cache_line_t),
        .DEPTH  (INDEX_COUNT)
    ) data_ram (
        .clk       (clk),
        .i_rd_en   (i_rd_en),
        .i_rd_addr (i_rd_index),
        .o_rd_data (rd_line),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr.index),
        .i_wr_data (i_wr.line)
    );

    // tag and line are undefined after reset, valid low marks them as unusable
    assign o_entry.valid = rd_valid_r;
    assign o_entry.dirty = rd_dirty_r;
    assign o_entry.tag   = rd_tag;
    assign o_entry.line  = rd_line;

endmodule

/* cache_top.sv */
`timescale 1ns/1ps

// direct-mapped cache store with its hit check
// a read issued in one cycle gives its result on the next
module cache_top (
    input  logic                   clk,
    input  logic                   i_rst_n,

    // write side
    input  logic                   i_wr_en,
    input  cache_pkg::cache_wr_t   i_wr,

    // read side, a new read may start every cycle
    input  logic                   i_rd_en,
    input  cache_pkg::cache_addr_t i_rd_addr,

    // result, there is no back-pressure
    output logic                   o_rd_valid,
    output cache_pkg::cache_rd_t   o_rd
);

    import cache_pkg::*;

    cache_entry_t entry;

    // the store only needs the index, the offset selects bytes outside this block
    cache_store store (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_wr_en    (i_wr_en),
        .i_wr       (i_wr),
        .i_rd_en    (i_rd_en),
        .i_rd_index (i_rd_addr.index),
        .o_entry    (entry)
    );

    cache_hit_check hit_check (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rd_en    (i_rd_en),
        .i_rd_tag   (i_rd_addr.tag),
        .i_entry    (entry),
        .o_rd_valid (o_rd_valid),
        .o_rd       (o_rd)
    );

endmodule

/* sdp_ram.sv */
`timescale 1ns/1ps

// simple dual-port RAM with one write port and one registered read port
// the payload type is a parameter so the same block serves tags and lines
module sdp_ram #(
    parameter type T_DATA = logic [31:0],
    parameter int DEPTH = 32,
    localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                  clk,

    // read port, data shows up on the edge after i_rd_en
    input  logic                  i_rd_en,
    input  logic [ADDR_WIDTH-1:0] i_rd_addr,
    output T_DATA                 o_rd_data,

    // write port
    input  logic                  i_wr_en,
    input  logic [ADDR_WIDTH-1:0] i_wr_addr,
    input  T_DATA                 i_wr_data
);

    T_DATA mem [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // a read and a write to the same address in one cycle return the old contents,
    // since the array update only lands after this edge
    // with i_rd_en low the output keeps the last value read
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

/* tb.f */
+incdir+.
cache_pkg.sv
sdp_ram.sv
cache_store.sv
cache_hit_check.sv
cache_top.sv
tb_clkgen.sv
cache_assert.sv
tb_cache_top.sv

/* tb_cache_top.sv */
`timescale 1ns/1ps

module tb_cache_top;

    import cache_pkg::*;

    localparam int RESULT_TIMEOUT = 4;
    localparam int DRAIN_TIMEOUT  = 16;
    localparam int RANDOM_CYCLES  = 400;
    localparam cache_tag_t TAG_BASE = cache_tag_t'(32'h002a_5000);

    logic         clk;
    logic         i_rst_n;
    logic         i_wr_en;
    cache_wr_t    i_wr;
    logic         i_rd_en;
    cache_addr_t  i_rd_addr;
    logic         o_rd_valid;
    cache_rd_t    o_rd;

    // the reference model keeps one entry of stored state per index
    logic         m_valid [INDEX_COUNT];
    logic         m_dirty [INDEX_COUNT];
    cache_tag_t   m_tag   [INDEX_COUNT];
    cache_line_t  m_line  [INDEX_COUNT];
    logic         m_known [INDEX_COUNT];

    // expected results wait in issue order next to a flag that says whether tag and line are defined
    cache_rd_t    want_q  [$];
    logic         known_q [$];

    int           error_count;
    int           check_count;
    int           test_count;
    int           test_reads;
    int           test_err_start;

    tb_clkgen #(.PERIOD_NS(4.0)) clkgen (.o_clk(clk));

    cache_top UUT (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_wr_en    (i_wr_en),
        .i_wr       (i_wr),
        .i_rd_en    (i_rd_en),
        .i_rd_addr  (i_rd_addr),
        .o_rd_valid (o_rd_valid),
        .o_rd       (o_rd)
    );

    // state bits of a same-cycle write reach the read while tag and line stay the old ones
    function automatic cache_rd_t expected_read(input cache_addr_t addr, input logic wr_en,
                                                input cache_wr_t wr);
        cache_rd_t r;
        logic      same;
        same    = wr_en && (wr.index == addr.index);
        r.valid = same ? wr.valid : m_valid[addr.index];
        r.dirty = same ? wr.dirty : m_dirty[addr.index];
        r.tag   = m_tag[addr.index];
        r.line  = m_line[addr.index];
        r.hit   = r.valid && (r.tag == addr.tag);
        return r;
    endfunction

    function automatic cache_line_t random_line();
        cache_line_t l;
        for (int w = 0; w < LINE_WIDTH / 32; w++) begin
            l[w*32 +: 32] = $urandom();
        end
        return l;
    endfunction

    function automatic cache_wr_t make_wr(input int index, input logic valid,
                                          input logic dirty, input cache_tag_t tag,
                                          input cache_line_t line);
        cache_wr_t w;
        w.index = INDEX_WIDTH'(index);
        w.valid = valid;
        w.dirty = dirty;
        w.tag   = tag;
        w.line  = line;
        return w;
    endfunction

    function automatic cache_addr_t make_addr(input cache_tag_t tag, input int index);
        cache_addr_t a;
        a.tag    = tag;
        a.index  = INDEX_WIDTH'(index);
        a.offset = OFFSET_WIDTH'($urandom());
        return a;
    endfunction

    function automatic int total_errors();
        return error_count + UUT.u_cache_assert.fail_count;
    endfunction

    task automatic check_field(input string name, input logic [LINE_WIDTH-1:0] got,
                               input logic [LINE_WIDTH-1:0] want);
        assert (got === want) else begin
            $display("Error: %s got %0h expected %0h", name, got, want);
            error_count++;
        end
    endtask

    // tag and line are only compared once the model knows what was written
    task automatic compare_result(input cache_rd_t got, input cache_rd_t want,
                                  input logic known);
        check_field("o_rd.valid", got.valid, want.valid);
        check_field("o_rd.dirty", got.dirty, want.dirty);
        if (known || !want.valid) begin
            check_field("o_rd.hit", got.hit, want.hit);
        end
        if (known) begin
            check_field("o_rd.tag", got.tag, want.tag);
            check_field("o_rd.line", got.line, want.line);
        end
        check_count++;
    endtask

    // results are sampled on the falling edge well away from the rising edge
    always begin : compare_results
        int        waited;
        cache_rd_t want;
        logic      known;
        @(negedge clk);
        if (want_q.size() > 0) begin
            waited = 0;
            while (!o_rd_valid && waited < RESULT_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!o_rd_valid) begin
                $display("timeout: o_rd_valid never rose for an outstanding read");
                error_count++;
            end else begin
                want  = want_q[0];
                known = known_q[0];
                compare_result(o_rd, want, known);
            end
            void'(want_q.pop_front());
            void'(known_q.pop_front());
        end else begin
            assert (!o_rd_valid) else begin
                $display("o_rd_valid rose while no read was outstanding");
                error_count++;
            end
        end
    end

    // the model is updated only after the expected result of this cycle is taken
    task automatic drive_cycle(input logic wr_en, input cache_wr_t wr, input logic rd_en,
                               input cache_addr_t addr);
        @(negedge clk);
        i_wr_en   = wr_en;
        i_wr      = wr;
        i_rd_en   = rd_en;
        i_rd_addr = addr;
        if (rd_en) begin
            want_q.push_back(expected_read(addr, wr_en, wr));
            known_q.push_back(m_known[addr.index]);
            test_reads++;
        end
        if (wr_en) begin
            m_valid[wr.index] = wr.valid;
            m_dirty[wr.index] = wr.dirty;
            m_tag[wr.index]   = wr.tag;
            m_line[wr.index]  = wr.line;
            m_known[wr.index] = 1'b1;
        end
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, 1'b0, '0);
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (want_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (want_q.size() > 0) begin
            $display("timeout: %0d expected results never arrived", want_q.size());
            error_count++;
        end
    endtask

    task automatic start_test();
        test_count++;
        test_reads     = 0;
        test_err_start = total_errors();
    endtask

    task automatic finish_test(input string name);
        idle_cycle();
        drain_results();
        $display("test %0d %s: %0d reads, %0d errors", test_count, name, test_reads,
                 total_errors() - test_err_start);
    endtask

    task automatic test_reset_reads();
        start_test();
        for (int i = 0; i < INDEX_COUNT; i++) begin
            drive_cycle(1'b0, '0, 1'b1, make_addr(TAG_BASE, i));
        end
        finish_test("reads after reset");
    endtask

    // writes go to indices 1, 5, 9 and so on and every odd write is dirty
    task automatic test_write_hits();
        start_test();
        for (int i = 0; i < 8; i++) begin
            drive_cycle(1'b1, make_wr(i * 4 + 1, 1'b1, i[0], TAG_BASE + cache_tag_t'(i),
                        random_line()), 1'b0, '0);
        end
        for (int i = 0; i < 8; i++) begin
            drive_cycle(1'b0, '0, 1'b1, make_addr(TAG_BASE + cache_tag_t'(i), i * 4 + 1));
        end
        finish_test("write then hit");
    endtask

    task automatic test_tag_misses();
        start_test();
        for (int i = 0; i < 8; i++) begin
            drive_cycle(1'b0, '0, 1'b1,
                        make_addr(TAG_BASE + cache_tag_t'(32'h100 + i), i * 4 + 1));
        end
        finish_test("tag miss with victim");
    endtask

    task automatic test_invalid_write();
        start_test();
        drive_cycle(1'b1, make_wr(10, 1'b0, 1'b1, TAG_BASE + cache_tag_t'(32'h40),
                                  random_line()),
                    1'b0, '0);
        drive_cycle(1'b0, '0, 1'b1, make_addr(TAG_BASE + cache_tag_t'(32'h40), 10));
        finish_test("write with valid low");
    endtask

    task automatic test_same_cycle();
        cache_tag_t new_tag;
        start_test();
        new_tag = TAG_BASE + cache_tag_t'(32'h200);
        drive_cycle(1'b1, make_wr(5, 1'b1, ~m_dirty[5], new_tag, random_line()),
                    1'b1, make_addr(new_tag, 5));
        drive_cycle(1'b1, make_wr(9, 1'b0, 1'b0, new_tag, random_line()),
                    1'b1, make_addr(m_tag[9], 9));
        idle_cycle();
        drive_cycle(1'b0, '0, 1'b1, make_addr(new_tag, 5));
        drive_cycle(1'b0, '0, 1'b1, make_addr(new_tag, 9));
        finish_test("same-cycle write and read");
    endtask

    // a small tag set keeps hits and misses both common
    task automatic test_random();
        logic        do_wr;
        logic        do_rd;
        cache_wr_t   wr;
        cache_addr_t addr;
        start_test();
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            do_wr = ($urandom_range(0, 1) == 1);
            do_rd = ($urandom_range(0, 3) != 0);
            wr    = make_wr($urandom_range(0, INDEX_COUNT - 1), $urandom_range(0, 3) != 0,
                            $urandom_range(0, 1) == 1,
                            TAG_BASE + cache_tag_t'($urandom_range(0, 3)), random_line());
            addr  = make_addr(TAG_BASE + cache_tag_t'($urandom_range(0, 3)),
                              $urandom_range(0, INDEX_COUNT - 1));
            drive_cycle(do_wr, wr, do_rd, addr);
        end
        finish_test("random traffic");
    endtask

    initial begin
        i_rst_n   = 1'b0;
        i_wr_en   = 1'b0;
        i_wr      = '0;
        i_rd_en   = 1'b0;
        i_rd_addr = '0;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        for (int i = 0; i < INDEX_COUNT; i++) begin
            m_valid[i] = 1'b0;
            m_dirty[i] = 1'b0;
            m_known[i] = 1'b0;
        end
        void'($urandom(32'h4e4faa8d));

        repeat (5) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        test_reset_reads();
        test_write_hits();
        test_tag_misses();
        test_invalid_write();
        test_same_cycle();
        test_random();

        $display("tests %0d, reads checked %0d, errors %0d", test_count, check_count,
                 total_errors());
        if (total_errors() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* tb_clkgen.sv */
`timescale 1ns/1ps

// free-running testbench clock, starts low
module tb_clkgen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

endmodule
